//--- logic/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// ir[15:12]
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not
	} lc3b_aluop;

	// 11 bits, travels with the instruction down the pipe
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		logic imm_sel;
		logic ld_reg;
		logic ld_cc;
		logic mem_read;
		logic mem_write;
	} lc3b_control_word;

	localparam lc3b_word reset_pc = 16'h0000;
	localparam int num_regs = 8;

endpackage : lc3b_isa_pkg

`default_nettype wire

//--- logic/lc3b_mem_pkg.sv
`default_nettype none

package lc3b_mem_pkg;

	localparam int mem_addr_width = 16;
	localparam int mem_data_width = 16;

	// which requester owns the physical port
	typedef enum logic [1:0] {
		idle,
		serve_i,
		serve_d
	} arb_state;

endpackage : lc3b_mem_pkg

`default_nettype wire

//--- logic/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if;

	logic [lc3b_mem_pkg::mem_addr_width-1:0] address;
	logic read;
	logic write;
	logic [lc3b_mem_pkg::mem_data_width-1:0] wdata;
	logic [lc3b_mem_pkg::mem_data_width-1:0] rdata;
	// one cycle, rdata valid with it
	logic resp;

	modport requester (
		output address,
		output read,
		output write,
		output wdata,
		input rdata,
		input resp
	);

	modport arbiter (
		input address,
		input read,
		input write,
		input wdata,
		output rdata,
		output resp
	);

endinterface : mem_port_if

`default_nettype wire

//--- logic/fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input logic dep_stall,
	input logic branch_taken,
	input lc3b_isa_pkg::lc3b_word branch_target,
	mem_port_if.requester i_port,
	output logic fd_valid,
	output lc3b_isa_pkg::lc3b_word fd_pc,
	output lc3b_isa_pkg::lc3b_word fd_ir
);

	lc3b_isa_pkg::lc3b_word pc;
	lc3b_isa_pkg::lc3b_word ir_buf;
	lc3b_isa_pkg::lc3b_word ir_word;
	logic ir_done;
	logic ir_ready;
	logic running;

	// word may have come back while the pipe was frozen
	assign ir_word = ir_done ? ir_buf : i_port.rdata;
	assign ir_ready = ir_done | i_port.resp;

	assign i_port.address = pc;
	assign i_port.read = running & ~ir_done & ~dep_stall;
	assign i_port.write = 1'b0;
	assign i_port.wdata = '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			pc <= lc3b_isa_pkg::reset_pc;
			ir_done <= 1'b0;
			fd_valid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (load_regs && branch_taken) begin
				pc <= branch_target;
				ir_done <= 1'b0;
				fd_valid <= 1'b0;
			end else if (load_regs && !dep_stall && ir_ready) begin
				pc <= pc + 16'd2;
				ir_done <= 1'b0;
				fd_valid <= 1'b1;
			end else if (!load_regs && i_port.resp) begin
				ir_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_regs && !dep_stall && ir_ready) begin
			fd_pc <= pc;
			fd_ir <= ir_word;
		end
		if (!load_regs && i_port.resp)
			ir_buf <= i_port.rdata;
	end

endmodule : fetch

`default_nettype wire

//--- logic/decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input logic flush,
	input logic fd_valid,
	input lc3b_isa_pkg::lc3b_word fd_pc,
	input lc3b_isa_pkg::lc3b_word fd_ir,
	input lc3b_isa_pkg::lc3b_reg ex_dr,
	input lc3b_isa_pkg::lc3b_reg mem_dr,
	input logic ex_ld_reg,
	input logic mem_ld_reg,
	input logic ex_ld_cc,
	input logic mem_ld_cc,
	input logic wb_valid,
	input lc3b_isa_pkg::lc3b_reg wb_reg,
	input lc3b_isa_pkg::lc3b_word wb_data,
	input logic wb_ld_reg,
	input logic wb_ld_cc,
	output logic dep_stall,
	output logic de_valid,
	output lc3b_isa_pkg::lc3b_control_word de_cw,
	output lc3b_isa_pkg::lc3b_word de_pc,
	output lc3b_isa_pkg::lc3b_word de_ir,
	output lc3b_isa_pkg::lc3b_word de_sr1,
	output lc3b_isa_pkg::lc3b_word de_sr2,
	output lc3b_isa_pkg::lc3b_nzp de_cc
);

	lc3b_isa_pkg::lc3b_word regs [lc3b_isa_pkg::num_regs];
	lc3b_isa_pkg::lc3b_nzp cc;
	lc3b_isa_pkg::lc3b_nzp wb_nzp;
	lc3b_isa_pkg::lc3b_control_word cw;
	lc3b_isa_pkg::lc3b_reg sr1;
	lc3b_isa_pkg::lc3b_reg sr2;
	logic known;
	logic use_sr1;
	logic use_sr2;
	logic use_cc;
	logic sr1_busy;
	logic sr2_busy;
	logic cc_busy;

	assign sr1 = fd_ir[8:6];
	// STR takes its data register from the dr field
	assign sr2 = (fd_ir[15:12] == lc3b_isa_pkg::op_str) ? fd_ir[11:9] : fd_ir[2:0];

	always_comb begin
		cw = '0;
		known = 1'b1;
		use_sr1 = 1'b0;
		use_sr2 = 1'b0;
		use_cc = 1'b0;
		case (fd_ir[15:12])
			lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
				if (fd_ir[15:12] == lc3b_isa_pkg::op_add) begin
					cw.opcode = lc3b_isa_pkg::op_add;
					cw.aluop = lc3b_isa_pkg::alu_add;
				end else begin
					cw.opcode = lc3b_isa_pkg::op_and;
					cw.aluop = lc3b_isa_pkg::alu_and;
				end
				cw.imm_sel = fd_ir[5];
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = ~fd_ir[5];
			end
			lc3b_isa_pkg::op_not: begin
				cw.opcode = lc3b_isa_pkg::op_not;
				cw.aluop = lc3b_isa_pkg::alu_not;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			lc3b_isa_pkg::op_ldr: begin
				cw.opcode = lc3b_isa_pkg::op_ldr;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				cw.mem_read = 1'b1;
				use_sr1 = 1'b1;
			end
			lc3b_isa_pkg::op_str: begin
				cw.opcode = lc3b_isa_pkg::op_str;
				cw.mem_write = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = 1'b1;
			end
			lc3b_isa_pkg::op_br: begin
				cw.opcode = lc3b_isa_pkg::op_br;
				use_cc = 1'b1;
			end
			// unsupported opcodes leave as bubbles
			default: known = 1'b0;
		endcase
	end

	// ex_* is the instruction in execute, mem_* the one in memory
	assign sr1_busy = (ex_ld_reg && ex_dr == sr1) || (mem_ld_reg && mem_dr == sr1) ||
		(wb_valid && wb_ld_reg && wb_reg == sr1);
	assign sr2_busy = (ex_ld_reg && ex_dr == sr2) || (mem_ld_reg && mem_dr == sr2) ||
		(wb_valid && wb_ld_reg && wb_reg == sr2);
	assign cc_busy = ex_ld_cc | mem_ld_cc | (wb_valid & wb_ld_cc);

	assign dep_stall = fd_valid & known &
		((use_sr1 & sr1_busy) | (use_sr2 & sr2_busy) | (use_cc & cc_busy));

	assign wb_nzp = wb_data[15] ? 3'b100 : ((wb_data == '0) ? 3'b010 : 3'b001);

	always_ff @(posedge clk) begin
		if (load_regs && wb_valid && wb_ld_reg)
			regs[wb_reg] <= wb_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cc <= '0;
			de_valid <= 1'b0;
		end else if (load_regs) begin
			if (wb_valid && wb_ld_cc)
				cc <= wb_nzp;
			de_valid <= fd_valid & known & ~dep_stall & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (load_regs) begin
			de_cw <= cw;
			de_pc <= fd_pc;
			de_ir <= fd_ir;
			de_sr1 <= regs[sr1];
			de_sr2 <= regs[sr2];
			de_cc <= cc;
		end
	end

endmodule : decode

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input logic flush,
	input logic de_valid,
	input lc3b_isa_pkg::lc3b_control_word de_cw,
	input lc3b_isa_pkg::lc3b_word de_pc,
	input lc3b_isa_pkg::lc3b_word de_ir,
	input lc3b_isa_pkg::lc3b_word de_sr1,
	input lc3b_isa_pkg::lc3b_word de_sr2,
	input lc3b_isa_pkg::lc3b_nzp de_cc,
	output logic ex_valid,
	output lc3b_isa_pkg::lc3b_control_word ex_cw,
	output lc3b_isa_pkg::lc3b_nzp ex_cc,
	output lc3b_isa_pkg::lc3b_reg ex_dr,
	output lc3b_isa_pkg::lc3b_word ex_result,
	output lc3b_isa_pkg::lc3b_word ex_address,
	output lc3b_isa_pkg::lc3b_word ex_store_data
);

	lc3b_isa_pkg::lc3b_word imm5;
	lc3b_isa_pkg::lc3b_word off6_x2;
	lc3b_isa_pkg::lc3b_word off9_x2;
	lc3b_isa_pkg::lc3b_word alu_b;
	lc3b_isa_pkg::lc3b_word alu_out;
	lc3b_isa_pkg::lc3b_word address;

	assign imm5 = {{11{de_ir[4]}}, de_ir[4:0]};
	assign off6_x2 = {{9{de_ir[5]}}, de_ir[5:0], 1'b0};
	assign off9_x2 = {{6{de_ir[8]}}, de_ir[8:0], 1'b0};
	assign alu_b = de_cw.imm_sel ? imm5 : de_sr2;

	always_comb begin
		case (de_cw.aluop)
			lc3b_isa_pkg::alu_and: alu_out = de_sr1 & alu_b;
			lc3b_isa_pkg::alu_not: alu_out = ~de_sr1;
			default: alu_out = de_sr1 + alu_b;
		endcase
	end

	// branch offset counts from the incremented pc
	assign address = (de_cw.opcode == lc3b_isa_pkg::op_br) ?
		de_pc + 16'd2 + off9_x2 : de_sr1 + off6_x2;

	always_ff @(posedge clk) begin
		if (reset)
			ex_valid <= 1'b0;
		else if (load_regs)
			ex_valid <= de_valid & ~flush;
	end

	always_ff @(posedge clk) begin
		if (load_regs) begin
			ex_cw <= de_cw;
			ex_cc <= de_cc;
			ex_dr <= de_ir[11:9];
			ex_result <= alu_out;
			ex_address <= address;
			ex_store_data <= de_sr2;
		end
	end

endmodule : execute

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
	input logic clk,
	input logic reset,
	input logic load_regs,
	input logic ex_valid,
	input lc3b_isa_pkg::lc3b_control_word ex_cw,
	input lc3b_isa_pkg::lc3b_nzp ex_cc,
	input lc3b_isa_pkg::lc3b_reg ex_dr,
	input lc3b_isa_pkg::lc3b_word ex_result,
	input lc3b_isa_pkg::lc3b_word ex_address,
	input lc3b_isa_pkg::lc3b_word ex_store_data,
	mem_port_if.requester d_port,
	output logic branch_taken,
	output lc3b_isa_pkg::lc3b_word branch_target,
	output logic wb_valid,
	output lc3b_isa_pkg::lc3b_reg wb_reg,
	output lc3b_isa_pkg::lc3b_word wb_data,
	output logic wb_ld_reg,
	output logic wb_ld_cc
);

	lc3b_isa_pkg::lc3b_word d_buf;
	lc3b_isa_pkg::lc3b_word load_word;
	logic d_done;

	// access finished early stays finished until the pipe moves
	assign d_port.read = ex_valid & ex_cw.mem_read & ~d_done;
	assign d_port.write = ex_valid & ex_cw.mem_write & ~d_done;
	assign d_port.address = ex_address;
	assign d_port.wdata = ex_store_data;
	assign load_word = d_done ? d_buf : d_port.rdata;

	// nzp field of BR sits where dr would be
	assign branch_taken = ex_valid & (ex_cw.opcode == lc3b_isa_pkg::op_br) & (|(ex_dr & ex_cc));
	assign branch_target = ex_address;

	always_ff @(posedge clk) begin
		if (reset) begin
			d_done <= 1'b0;
			wb_valid <= 1'b0;
		end else if (load_regs) begin
			d_done <= 1'b0;
			wb_valid <= ex_valid;
		end else if (d_port.resp) begin
			d_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!load_regs && d_port.resp)
			d_buf <= d_port.rdata;
		if (load_regs) begin
			wb_reg <= ex_dr;
			wb_data <= ex_cw.mem_read ? load_word : ex_result;
			wb_ld_reg <= ex_cw.ld_reg;
			wb_ld_cc <= ex_cw.ld_cc;
		end
	end

endmodule : mem_stage

`default_nettype wire

//--- logic/arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module arbiter (
	input logic clk,
	input logic reset,
	mem_port_if.arbiter i_port,
	mem_port_if.arbiter d_port,
	input logic pmem_resp,
	input logic [lc3b_mem_pkg::mem_data_width-1:0] pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output logic [lc3b_mem_pkg::mem_addr_width-1:0] pmem_address,
	output logic [lc3b_mem_pkg::mem_data_width-1:0] pmem_wdata
);

	lc3b_mem_pkg::arb_state state;
	lc3b_mem_pkg::arb_state grant;
	logic i_req;
	logic d_req;

	assign i_req = i_port.read | i_port.write;
	assign d_req = d_port.read | d_port.write;

	// grant from idle in the same cycle, data first
	always_comb begin
		grant = state;
		if (state == lc3b_mem_pkg::idle) begin
			if (d_req)
				grant = lc3b_mem_pkg::serve_d;
			else if (i_req)
				grant = lc3b_mem_pkg::serve_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || pmem_resp)
			state <= lc3b_mem_pkg::idle;
		else
			state <= grant;
	end

	always_comb begin
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_address = i_port.address;
		pmem_wdata = i_port.wdata;
		case (grant)
			lc3b_mem_pkg::serve_i: begin
				pmem_read = i_port.read;
				pmem_write = i_port.write;
			end
			lc3b_mem_pkg::serve_d: begin
				pmem_read = d_port.read;
				pmem_write = d_port.write;
				pmem_address = d_port.address;
				pmem_wdata = d_port.wdata;
			end
			default: begin
			end
		endcase
	end

	assign i_port.resp = (grant == lc3b_mem_pkg::serve_i) & pmem_resp;
	assign d_port.resp = (grant == lc3b_mem_pkg::serve_d) & pmem_resp;
	assign i_port.rdata = (grant == lc3b_mem_pkg::serve_i) ? pmem_rdata : '0;
	assign d_port.rdata = (grant == lc3b_mem_pkg::serve_d) ? pmem_rdata : '0;

endmodule : arbiter

`default_nettype wire

//--- logic/lc3b_core.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_core (
	input logic clk,
	input logic reset,
	input logic pmem_resp,
	input lc3b_isa_pkg::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_isa_pkg::lc3b_word pmem_address,
	output lc3b_isa_pkg::lc3b_word pmem_wdata
);

	mem_port_if i_port ();
	mem_port_if d_port ();

	logic load_regs;
	logic dep_stall;
	logic branch_taken;
	lc3b_isa_pkg::lc3b_word branch_target;

	// fetch/decode
	logic fd_valid;
	lc3b_isa_pkg::lc3b_word fd_pc;
	lc3b_isa_pkg::lc3b_word fd_ir;

	// decode/execute
	logic de_valid;
	lc3b_isa_pkg::lc3b_control_word de_cw;
	lc3b_isa_pkg::lc3b_word de_pc;
	lc3b_isa_pkg::lc3b_word de_ir;
	lc3b_isa_pkg::lc3b_word de_sr1;
	lc3b_isa_pkg::lc3b_word de_sr2;
	lc3b_isa_pkg::lc3b_nzp de_cc;

	// execute/memory
	logic ex_valid;
	lc3b_isa_pkg::lc3b_control_word ex_cw;
	lc3b_isa_pkg::lc3b_nzp ex_cc;
	lc3b_isa_pkg::lc3b_reg ex_dr;
	lc3b_isa_pkg::lc3b_word ex_result;
	lc3b_isa_pkg::lc3b_word ex_address;
	lc3b_isa_pkg::lc3b_word ex_store_data;

	// memory/write-back
	logic wb_valid;
	lc3b_isa_pkg::lc3b_reg wb_reg;
	lc3b_isa_pkg::lc3b_word wb_data;
	logic wb_ld_reg;
	logic wb_ld_cc;

	// hazard sources, qualified by valid
	logic de_ld_reg;
	logic de_ld_cc;
	logic ex_ld_reg;
	logic ex_ld_cc;

	assign de_ld_reg = de_valid & de_cw.ld_reg;
	assign de_ld_cc = de_valid & de_cw.ld_cc;
	assign ex_ld_reg = ex_valid & ex_cw.ld_reg;
	assign ex_ld_cc = ex_valid & ex_cw.ld_cc;

	// whole pipe waits on any outstanding access
	assign load_regs = (~(i_port.read | i_port.write) | i_port.resp) &
		(~(d_port.read | d_port.write) | d_port.resp);

	fetch fetch_int (
		.clk,
		.reset,
		.load_regs,
		.dep_stall,
		.branch_taken,
		.branch_target,
		.i_port,
		.fd_valid,
		.fd_pc,
		.fd_ir
	);

	decode decode_int (
		.clk,
		.reset,
		.load_regs,
		.flush(branch_taken),
		.fd_valid,
		.fd_pc,
		.fd_ir,
		.ex_dr(de_ir[11:9]),
		.mem_dr(ex_dr),
		.ex_ld_reg(de_ld_reg),
		.mem_ld_reg(ex_ld_reg),
		.ex_ld_cc(de_ld_cc),
		.mem_ld_cc(ex_ld_cc),
		.wb_valid,
		.wb_reg,
		.wb_data,
		.wb_ld_reg,
		.wb_ld_cc,
		.dep_stall,
		.de_valid,
		.de_cw,
		.de_pc,
		.de_ir,
		.de_sr1,
		.de_sr2,
		.de_cc
	);

	execute execute_int (
		.clk,
		.reset,
		.load_regs,
		.flush(branch_taken),
		.de_valid,
		.de_cw,
		.de_pc,
		.de_ir,
		.de_sr1,
		.de_sr2,
		.de_cc,
		.ex_valid,
		.ex_cw,
		.ex_cc,
		.ex_dr,
		.ex_result,
		.ex_address,
		.ex_store_data
	);

	mem_stage mem_int (
		.clk,
		.reset,
		.load_regs,
		.ex_valid,
		.ex_cw,
		.ex_cc,
		.ex_dr,
		.ex_result,
		.ex_address,
		.ex_store_data,
		.d_port,
		.branch_taken,
		.branch_target,
		.wb_valid,
		.wb_reg,
		.wb_data,
		.wb_ld_reg,
		.wb_ld_cc
	);

	arbiter arbiter_int (
		.clk,
		.reset,
		.i_port,
		.d_port,
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

endmodule : lc3b_core

`default_nettype wire

//--- tests/lc3b_core_properties.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_core_properties (
	input logic clk,
	input logic reset,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic [15:0] pmem_address,
	input logic [15:0] pmem_wdata
);

	read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high in the same cycle");

	// a waiting request keeps its kind, address and data
	request_stable: assert property (@(posedge clk) disable iff (reset)
		(pmem_read || pmem_write) && !pmem_resp |=>
		pmem_read == $past(pmem_read) && pmem_write == $past(pmem_write) &&
		$stable(pmem_address) && $stable(pmem_wdata))
		else $error("memory request changed before pmem_resp");

	quiet_in_reset: assert property (@(posedge clk)
		reset |=> !pmem_read && !pmem_write)
		else $error("memory request issued while in reset");

endmodule : lc3b_core_properties

bind lc3b_core lc3b_core_properties i_props (
	.clk(clk),
	.reset(reset),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.pmem_address(pmem_address),
	.pmem_wdata(pmem_wdata)
);

`default_nettype wire

//--- tests/lc3b_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_core_checker #(
	parameter int num_stores = 11
) (
	input logic clk,
	input logic reset,
	input logic finished,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input logic [15:0] pmem_address,
	input logic [15:0] pmem_wdata,
	input logic [15:0] expected_addr [num_stores],
	input logic [15:0] expected_data [num_stores],
	output int store_count,
	output int error_count
);

	logic first_read_seen;
	logic reported;

	initial begin
		store_count = 0;
		error_count = 0;
		first_read_seen = 1'b0;
		reported = 1'b0;
	end

	always @(posedge clk) begin
		if (reset) begin
			if (pmem_read === 1'b1 || pmem_write === 1'b1) begin
				$display("memory access seen during reset at %0t", $time);
				error_count = error_count + 1;
			end
		end else begin
			if (pmem_read === 1'b1 && !first_read_seen) begin
				first_read_seen = 1'b1;
				if (pmem_address !== lc3b_isa_pkg::reset_pc) begin
					$display("FAIL %0t: first fetch at %h, not at the reset pc",
						$time, pmem_address);
					error_count = error_count + 1;
				end
			end
			// a store is accepted on its resp
			if (pmem_write === 1'b1 && pmem_resp === 1'b1) begin
				if (store_count >= num_stores) begin
					$display("extra store to %h with data %h at %0t",
						pmem_address, pmem_wdata, $time);
					error_count = error_count + 1;
				end else if (pmem_address !== expected_addr[store_count] ||
					pmem_wdata !== expected_data[store_count]) begin
					$display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h",
						$time, store_count, pmem_wdata, pmem_address,
						expected_data[store_count], expected_addr[store_count]);
					error_count = error_count + 1;
				end
				store_count = store_count + 1;
			end
		end
		if (finished && !reported) begin
			reported = 1'b1;
			if (store_count < num_stores) begin
				$display("%0d of %0d expected stores never happened",
					num_stores - store_count, num_stores);
				error_count = error_count + 1;
			end
		end
	end

endmodule : lc3b_core_checker

`default_nettype wire

//--- tests/lc3b_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_core_tb;

	localparam int num_instr = 38;
	localparam int num_stores = 11;
	localparam int max_latency = 4;
	localparam longint timeout_ns = 64'd40 * max_latency * num_instr * 100;
	// address of the closing self-loop branch
	localparam logic [15:0] last_pc = 16'(2 * (num_instr - 1));

	logic clk;
	logic reset;
	logic finished;
	logic pmem_resp;
	logic [15:0] pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic [15:0] pmem_address;
	logic [15:0] pmem_wdata;
	int store_count;
	int error_count;

	logic [15:0] mem [256];
	logic [31:0] lcg_state;
	int latency;
	int wait_cnt;

	// R7 becomes 0x80, then alu, load, and n/z/p branch cases
	logic [15:0] prog_words [num_instr] = '{
		16'h5FE0, 16'h1FE8, 16'h1FC7, 16'h1FC7, 16'h1FC7, 16'h1FC7,
		16'h5260, 16'h126D, 16'h73C0, 16'h147A, 16'h5642, 16'h98FF,
		16'h75C1, 16'h77C2, 16'h79C3, 16'h1B01, 16'h5D2F, 16'h7BC4,
		16'h7DC5, 16'h63DE, 16'h1461, 16'h75C6, 16'h0401, 16'h73C7,
		16'h0801, 16'h73C8, 16'h56E0, 16'h0201, 16'h7BC9, 16'h0401,
		16'h7BCA, 16'h16E3, 16'h0801, 16'h77CB, 16'h0201, 16'h77CC,
		16'h7DCD, 16'h0FFF
	};

	logic [15:0] expected_addr [num_stores] = '{
		16'h0080, 16'h0082, 16'h0084, 16'h0086, 16'h0088, 16'h008A,
		16'h008C, 16'h008E, 16'h0092, 16'h0096, 16'h009A
	};
	logic [15:0] expected_data [num_stores] = '{
		16'h000D, 16'h0007, 16'h0005, 16'hFFFA, 16'h0007, 16'h000A,
		16'hA55F, 16'hA55E, 16'h0007, 16'h0003, 16'h000A
	};

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	lc3b_core i_dut (
		.clk(clk),
		.reset(reset),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

	lc3b_core_checker #(.num_stores(num_stores)) i_checker (
		.clk(clk),
		.reset(reset),
		.finished(finished),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_resp(pmem_resp),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.expected_addr(expected_addr),
		.expected_data(expected_data),
		.store_count(store_count),
		.error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model, answers after 1 to 4 cycles
	always @(negedge clk) begin
		if (reset || pmem_resp) begin
			pmem_resp = 1'b0;
			wait_cnt = 0;
		end else if (pmem_read || pmem_write) begin
			wait_cnt = wait_cnt + 1;
			if (wait_cnt >= latency) begin
				if (pmem_write)
					mem[pmem_address[8:1]] = pmem_wdata;
				pmem_rdata = mem[pmem_address[8:1]];
				pmem_resp = 1'b1;
				lcg_state = lcg_next(lcg_state);
				latency = 1 + int'(lcg_state[17:16]);
			end
		end
	end

	initial begin
		#(timeout_ns);
		$display("timeout after %0d ns with %0d of %0d stores seen",
			timeout_ns, store_count, num_stores);
		$display("summary: %0d check errors, 1 timeout", error_count);
		$display("sim failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		finished = 1'b0;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		wait_cnt = 0;
		lcg_state = 32'ha20f_1560;
		latency = 1;
		// fill word carries its own index
		for (int i = 0; i < 256; i++)
			mem[i] = {8'ha5, i[7:0]};
		for (int row = 0; row < num_instr; row++)
			mem[row] = prog_words[row];

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// run until the program reaches its closing loop
		while (!(pmem_read === 1'b1 && pmem_address === last_pc))
			@(negedge clk);
		// the final loop must not store anything more
		repeat (200) @(posedge clk);
		@(negedge clk);
		finished = 1'b1;
		repeat (2) @(posedge clk);

		$display("summary: %0d check errors, 0 timeouts", error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule : lc3b_core_tb

`default_nettype wire

//--- project.f
logic/lc3b_isa_pkg.sv
logic/lc3b_mem_pkg.sv
logic/mem_port_if.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_stage.sv
logic/arbiter.sv
logic/lc3b_core.sv
tests/lc3b_core_properties.sv
tests/lc3b_core_checker.sv
tests/lc3b_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module lc3b_core_tb \
		-f project.f -o lc3b_sim
	./obj_dir/lc3b_sim | tee sim.log
	grep -q "sim passed" sim.log
	! grep -q "sim failed" sim.log

clean:
	rm -rf obj_dir sim.log
